// File: imuldiv_core_pkg.sv
/*
 * core constants of the iterative multiply/divide engines
 * operand widths, step count, engine states and the multiplier control word
 */
package imuldiv_core_pkg;

  // operand and double-width result
  localparam int data_width = 32;
  localparam int prod_width = 2 * data_width;

  // one compute step per operand bit
  localparam int iter_count = 32;
  // wide enough to hold iter_count - 1
  localparam int count_width = 6;

  // sequencing states shared by both engines
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } engine_state_e;

  // --------------------
  // multiplier control word
  // --------------------
  // mux_sel low loads or clears, mux_sel high shifts or accumulates
  typedef struct packed {
    logic a_en;
    logic a_mux_sel;
    logic b_en;
    logic b_mux_sel;
    logic result_en;
    logic result_mux_sel;
    logic sign_en;
  } mul_ctrl_t;

endpackage

// File: imuldiv_msg_pkg.sv
/*
 * request and response messages of the multiply/divide unit
 * one 64-bit result word read as a product or as a remainder/quotient pair
 */
package imuldiv_msg_pkg;

  import imuldiv_core_pkg::*;

  // operation code carried by requests and echoed by responses
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } imuldiv_op_e;

  // request: op in the top bits, then a and b
  typedef struct packed {
    imuldiv_op_e           op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
  } imuldiv_req_t;

  // divider view, remainder in the upper half
  typedef struct packed {
    logic [data_width-1:0] rem;
    logic [data_width-1:0] quot;
  } div_result_t;

  // same word, decoded by op
  typedef union packed {
    logic signed [prod_width-1:0] prod;
    div_result_t                  div;
  } imuldiv_result_u;

  // response tagged with the op that produced it
  typedef struct packed {
    imuldiv_op_e     op;
    imuldiv_result_u result;
  } imuldiv_resp_t;

endpackage

// File: imuldiv_mul_dpath.sv
/*
 * shift-add multiplier datapath
 * unsigned magnitude product with the sign applied at the output
 */
module imuldiv_mul_dpath
  import imuldiv_core_pkg::*, imuldiv_msg_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  imuldiv_req_t    req_msg,
  input  mul_ctrl_t       ctrl,
  output logic            b_lsb,
  output imuldiv_result_u result
);

  // --------------------
  // operand preparation
  // --------------------
  logic                  a_sign;
  logic                  b_sign;
  logic [data_width-1:0] a_mag;
  logic [data_width-1:0] b_mag;

  assign a_sign = req_msg.a[data_width-1];
  assign b_sign = req_msg.b[data_width-1];
  // most negative value maps to its own bit pattern, fine as unsigned
  assign a_mag  = a_sign ? (~req_msg.a + 1'b1) : req_msg.a;
  assign b_mag  = b_sign ? (~req_msg.b + 1'b1) : req_msg.b;

  // --------------------
  // step registers
  // --------------------
  // multiplicand, widened so it can shift left 32 times
  logic [prod_width-1:0] a_reg;
  // multiplier, consumed from the lsb
  logic [data_width-1:0] b_reg;
  logic [prod_width-1:0] acc_reg;
  logic                  sign_reg;

  logic [prod_width-1:0] a_mux_out;
  logic [data_width-1:0] b_mux_out;
  logic [prod_width-1:0] acc_mux_out;

  assign a_mux_out   = ctrl.a_mux_sel ? (a_reg << 1) : {{data_width{1'b0}}, a_mag};
  assign b_mux_out   = ctrl.b_mux_sel ? (b_reg >> 1) : b_mag;
  // clear on load, add shifted multiplicand on a set multiplier bit
  assign acc_mux_out = ctrl.result_mux_sel ? (acc_reg + a_reg) : '0;

  always_ff @(posedge clk) begin
    if (ctrl.a_en) begin
      a_reg <= a_mux_out;
    end
    if (ctrl.b_en) begin
      b_reg <= b_mux_out;
    end
  end

  // accumulator and sign start from a known value
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_reg  <= '0;
      sign_reg <= 1'b0;
    end else begin
      if (ctrl.result_en) begin
        acc_reg <= acc_mux_out;
      end
      if (ctrl.sign_en) begin
        // product negative when exactly one operand is
        sign_reg <= a_sign ^ b_sign;
      end
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign b_lsb = b_reg[0];

  // final negation of the magnitude product
  assign result.prod = sign_reg ? (~acc_reg + 1'b1) : acc_reg;

endmodule

// File: imuldiv_mul_ctrl.sv
/*
 * multiplier control FSM
 * sequences load, 32 shift-add steps and the response hold
 */
module imuldiv_mul_ctrl
  import imuldiv_core_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      req_val,
  input  logic      resp_rdy,
  input  logic      b_lsb,
  output logic      req_rdy,
  output logic      resp_val,
  output mul_ctrl_t ctrl
);

  engine_state_e          state;
  logic [count_width-1:0] count;

  logic req_go;
  logic resp_go;
  logic last_step;

  // handshake transfers
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  // step counter runs 0 .. iter_count-1
  assign last_step = (count == count_width'(iter_count - 1));

  // --------------------
  // state and counter
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last_step) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          // result held until taken
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------
  // control word
  // --------------------
  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    ctrl     = '0;
    case (state)
      st_idle: begin
        req_rdy = 1'b1;
        // load operands, clear product, catch sign, all on the accepting edge
        ctrl.a_en      = req_val;
        ctrl.b_en      = req_val;
        ctrl.result_en = req_val;
        ctrl.sign_en   = req_val;
      end
      st_calc: begin
        ctrl.a_en           = 1'b1;
        ctrl.a_mux_sel      = 1'b1;
        ctrl.b_en           = 1'b1;
        ctrl.b_mux_sel      = 1'b1;
        // add only when the current multiplier bit is set
        ctrl.result_en      = b_lsb;
        ctrl.result_mux_sel = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

// File: imuldiv_int_mul_iterative.sv
/*
 * iterative signed multiplier engine
 * control FSM and shift-add datapath behind val/rdy ports
 */
module imuldiv_int_mul_iterative
  import imuldiv_core_pkg::*, imuldiv_msg_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_req_t  req_msg,
  input  logic          req_val,
  output logic          req_rdy,
  output imuldiv_resp_t resp_msg,
  output logic          resp_val,
  input  logic          resp_rdy
);

  mul_ctrl_t       ctrl;
  logic            b_lsb;
  imuldiv_result_u result;
  // op tag of the operation in flight
  imuldiv_op_e     op_reg;

  // decides what the datapath does each cycle
  imuldiv_mul_ctrl i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .b_lsb    (b_lsb),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .ctrl     (ctrl)
  );

  // registers, shift-add step, sign fix
  imuldiv_mul_dpath i_dpath (
    .clk     (clk),
    .reset   (reset),
    .req_msg (req_msg),
    .ctrl    (ctrl),
    .b_lsb   (b_lsb),
    .result  (result)
  );

  // tag captured with the operands
  always_ff @(posedge clk) begin
    if (req_val && req_rdy) begin
      op_reg <= req_msg.op;
    end
  end

  always_comb begin
    resp_msg.op     = op_reg;
    resp_msg.result = result;
  end

endmodule

// File: imuldiv_int_div_iterative.sv
/*
 * iterative restoring divider engine
 * signed and unsigned quotient and remainder, one trial subtraction per cycle
 */
module imuldiv_int_div_iterative
  import imuldiv_core_pkg::*, imuldiv_msg_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_req_t  req_msg,
  input  logic          req_val,
  output logic          req_rdy,
  output imuldiv_resp_t resp_msg,
  output logic          resp_val,
  input  logic          resp_rdy
);

  // --------------------
  // control
  // --------------------
  engine_state_e          state;
  logic [count_width-1:0] count;

  logic req_go;
  logic resp_go;
  logic last_step;

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_step = (count == count_width'(iter_count - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last_step) begin
            state <= st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------
  // operand preparation
  // --------------------
  logic                  is_signed;
  logic                  a_neg;
  logic                  b_neg;
  logic [data_width-1:0] a_mag;
  logic [data_width-1:0] b_mag;

  // only op_div looks at sign bits
  assign is_signed = (req_msg.op == op_div);
  assign a_neg     = is_signed && req_msg.a[data_width-1];
  assign b_neg     = is_signed && req_msg.b[data_width-1];
  assign a_mag     = a_neg ? (~req_msg.a + 1'b1) : req_msg.a;
  assign b_mag     = b_neg ? (~req_msg.b + 1'b1) : req_msg.b;

  // --------------------
  // trial subtraction
  // --------------------
  imuldiv_op_e           op_reg;
  // partial remainder in the upper half, quotient bits shift in from the right
  logic [prod_width-1:0] rq_reg;
  logic [data_width-1:0] divisor_reg;
  // kept whole for the divide-by-zero remainder
  logic [data_width-1:0] dividend_reg;
  logic                  quot_neg_reg;
  logic                  rem_neg_reg;
  logic                  div_zero_reg;

  // shifted remainder can reach 33 bits, one extra bit for the borrow
  logic [data_width+1:0] trial;
  logic [prod_width-1:0] rq_next;

  assign trial = {1'b0, rq_reg[prod_width-1:data_width-1]} - {2'b00, divisor_reg};

  // borrow set means restore, otherwise keep the difference and shift in a one
  assign rq_next = trial[data_width+1]
                 ? {rq_reg[prod_width-2:0], 1'b0}
                 : {trial[data_width-1:0], rq_reg[data_width-2:0], 1'b1};

  always_ff @(posedge clk) begin
    if (req_go) begin
      op_reg       <= req_msg.op;
      rq_reg       <= {{data_width{1'b0}}, a_mag};
      divisor_reg  <= b_mag;
      dividend_reg <= req_msg.a;
      quot_neg_reg <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg_reg  <= a_neg;
      div_zero_reg <= (req_msg.b == '0);
    end else if (state == st_calc) begin
      rq_reg <= rq_next;
    end
  end

  // --------------------
  // result fix-up
  // --------------------
  logic [data_width-1:0] quot_mag;
  logic [data_width-1:0] rem_mag;

  assign quot_mag = rq_reg[data_width-1:0];
  assign rem_mag  = rq_reg[prod_width-1:data_width];

  // most negative / -1 gives magnitude 2^31 with no negation, equal to the dividend
  always_comb begin
    resp_msg.op = op_reg;
    if (div_zero_reg) begin
      resp_msg.result.div.quot = '1;
      resp_msg.result.div.rem  = dividend_reg;
    end else begin
      resp_msg.result.div.quot = quot_neg_reg ? (~quot_mag + 1'b1) : quot_mag;
      resp_msg.result.div.rem  = rem_neg_reg ? (~rem_mag + 1'b1) : rem_mag;
    end
  end

endmodule

// File: imuldiv_dispatch.sv
/*
 * request dispatcher of the multiply/divide unit
 * steers one request at a time to an engine and returns its response
 */
module imuldiv_dispatch
  import imuldiv_msg_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_req_t  req_msg,
  input  logic          req_val,
  output logic          req_rdy,
  output imuldiv_resp_t resp_msg,
  output logic          resp_val,
  input  logic          resp_rdy,
  output imuldiv_req_t  mul_req_msg,
  output logic          mul_req_val,
  input  logic          mul_req_rdy,
  input  imuldiv_resp_t mul_resp_msg,
  input  logic          mul_resp_val,
  output logic          mul_resp_rdy,
  output imuldiv_req_t  div_req_msg,
  output logic          div_req_val,
  input  logic          div_req_rdy,
  input  imuldiv_resp_t div_resp_msg,
  input  logic          div_resp_val,
  output logic          div_resp_rdy
);

  // one operation in flight, and which engine owns it
  logic busy;
  logic sel_div;
  logic req_is_div;

  // both divide ops go to the divider
  assign req_is_div = (req_msg.op != op_mul);

  // --------------------
  // request side
  // --------------------
  assign mul_req_msg = req_msg;
  assign div_req_msg = req_msg;
  assign mul_req_val = req_val && !busy && !req_is_div;
  assign div_req_val = req_val && !busy && req_is_div;
  assign req_rdy     = !busy && (req_is_div ? div_req_rdy : mul_req_rdy);

  // --------------------
  // response side
  // --------------------
  assign resp_msg     = sel_div ? div_resp_msg : mul_resp_msg;
  assign resp_val     = busy && (sel_div ? div_resp_val : mul_resp_val);
  assign mul_resp_rdy = resp_rdy && busy && !sel_div;
  assign div_resp_rdy = resp_rdy && busy && sel_div;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      sel_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy    <= 1'b1;
      sel_div <= req_is_div;
    end else if (resp_val && resp_rdy) begin
      // free again on the response transfer
      busy <= 1'b0;
    end
  end

endmodule

// File: imuldiv_unit.sv
/*
 * iterative integer multiply/divide unit
 * dispatcher in front of the multiplier and divider engines
 */
module imuldiv_unit
  import imuldiv_msg_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  imuldiv_req_t  req_msg,
  input  logic          req_val,
  output logic          req_rdy,
  output imuldiv_resp_t resp_msg,
  output logic          resp_val,
  input  logic          resp_rdy
);

  // multiplier channels
  imuldiv_req_t  mul_req_msg;
  logic          mul_req_val;
  logic          mul_req_rdy;
  imuldiv_resp_t mul_resp_msg;
  logic          mul_resp_val;
  logic          mul_resp_rdy;

  // divider channels
  imuldiv_req_t  div_req_msg;
  logic          div_req_val;
  logic          div_req_rdy;
  imuldiv_resp_t div_resp_msg;
  logic          div_resp_val;
  logic          div_resp_rdy;

  imuldiv_dispatch i_dispatch (
    .clk          (clk),
    .reset        (reset),
    .req_msg      (req_msg),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_msg     (resp_msg),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .mul_req_msg  (mul_req_msg),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .mul_resp_msg (mul_resp_msg),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy),
    .div_req_msg  (div_req_msg),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_resp_msg (div_resp_msg),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy)
  );

  imuldiv_int_mul_iterative i_mul (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (mul_req_msg),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_msg (mul_resp_msg),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

  imuldiv_int_div_iterative i_div (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (div_req_msg),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_msg (div_resp_msg),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy)
  );

endmodule

// File: tb_imuldiv_unit.sv
/*
 * testbench of the multiply/divide unit
 * random requests with back-pressure, checked against a model of the arithmetic
 */
module tb_imuldiv_unit
  import imuldiv_core_pkg::*, imuldiv_msg_pkg::*;
();

  localparam int num_reqs     = 400;
  localparam int reset_cycles = 16;
  // resp_val is first seen this many cycles after the accept cycle
  localparam int resp_latency = iter_count + 1;
  // worst case per request plus the reset time
  localparam int max_cycles   = num_reqs * (resp_latency + 40) + reset_cycles;

  logic          clk;
  logic          reset;
  imuldiv_req_t  req_msg;
  logic          req_val;
  logic          req_rdy;
  imuldiv_resp_t resp_msg;
  logic          resp_val;
  logic          resp_rdy;

  // stimulus and expected responses, oldest first
  imuldiv_req_t  req_q[$];
  imuldiv_resp_t exp_q[$];

  int   next_idx;
  int   cycle;
  // cycles since the accept of the operation in flight
  int   age;
  logic in_flight;

  imuldiv_unit i_imuldiv_unit (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // --------------------
  // error handling
  // --------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_ctrl(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      fail_run($sformatf("FAILED %s: got %h expected %h at cycle %0d", name, act, exp, cycle));
    end
  endtask

  // op tag first, then the view that the op selects
  task automatic check_resp(input imuldiv_resp_t act, input imuldiv_resp_t exp);
    if (act.op !== exp.op) begin
      fail_run($sformatf("FAILED resp_msg.op: got %h expected %h", act.op, exp.op));
    end else if (exp.op == op_mul) begin
      if (act.result.prod !== exp.result.prod) begin
        fail_run($sformatf("FAILED resp_msg.result.prod: got %h expected %h",
                           act.result.prod, exp.result.prod));
      end
    end else if (act.result.div.quot !== exp.result.div.quot) begin
      fail_run($sformatf("FAILED resp_msg.result.div.quot: got %h expected %h",
                         act.result.div.quot, exp.result.div.quot));
    end else if (act.result.div.rem !== exp.result.div.rem) begin
      fail_run($sformatf("FAILED resp_msg.result.div.rem: got %h expected %h",
                         act.result.div.rem, exp.result.div.rem));
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  function automatic imuldiv_resp_t model_resp(input imuldiv_req_t req);
    imuldiv_resp_t r;
    int            sa;
    int            sb;
    longint        prod;
    sa   = req.a;
    sb   = req.b;
    r    = '0;
    r.op = req.op;
    case (req.op)
      op_mul: begin
        // both operands sign extended to 64 bits
        prod          = longint'(sa) * longint'(sb);
        r.result.prod = prod;
      end
      op_div: begin
        if (req.b == 32'h0) begin
          r.result.div.quot = '1;
          r.result.div.rem  = req.a;
        end else if (req.a == 32'h8000_0000 && req.b == 32'hffff_ffff) begin
          // overflow wraps back to the dividend
          r.result.div.quot = req.a;
          r.result.div.rem  = '0;
        end else begin
          // truncating division, remainder keeps the dividend sign
          r.result.div.quot = sa / sb;
          r.result.div.rem  = sa % sb;
        end
      end
      default: begin
        if (req.b == 32'h0) begin
          r.result.div.quot = '1;
          r.result.div.rem  = req.a;
        end else begin
          r.result.div.quot = req.a / req.b;
          r.result.div.rem  = req.a % req.b;
        end
      end
    endcase
    return r;
  endfunction

  // --------------------
  // stimulus
  // --------------------
  function automatic imuldiv_req_t make_req(input imuldiv_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    imuldiv_req_t r;
    r.op = op;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  // one time in eight a corner value
  function automatic logic [31:0] rand_operand();
    logic [31:0] v;
    if ($urandom_range(7) == 0) begin
      case ($urandom_range(3))
        0:       v = 32'h0000_0000;
        1:       v = 32'h0000_0001;
        2:       v = 32'hffff_ffff;
        default: v = 32'h8000_0000;
      endcase
    end else begin
      v = $urandom;
    end
    return v;
  endfunction

  task automatic build_requests();
    // corner cases up front so every run has them
    req_q.push_back(make_req(op_mul, 32'h8000_0000, 32'hffff_ffff));
    req_q.push_back(make_req(op_mul, 32'h8000_0000, 32'h8000_0000));
    req_q.push_back(make_req(op_mul, 32'hffff_ffff, 32'h0000_0000));
    req_q.push_back(make_req(op_div, 32'h8000_0000, 32'hffff_ffff));
    req_q.push_back(make_req(op_div, 32'hffff_fff9, 32'h0000_0002));
    req_q.push_back(make_req(op_div, 32'hffff_fff9, 32'h0000_0000));
    req_q.push_back(make_req(op_divu, 32'h1234_5678, 32'h0000_0000));
    req_q.push_back(make_req(op_divu, 32'hffff_ffff, 32'h0000_0001));
    while (req_q.size() < num_reqs) begin
      req_q.push_back(make_req(imuldiv_op_e'($urandom_range(2)), rand_operand(),
                               rand_operand()));
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  // outputs sampled at the falling edge, inputs driven at the rising edge
  initial begin
    logic accept;
    logic give;
    void'($urandom(32'hafdf_aba8));
    reset     = 1'b1;
    req_msg   = '0;
    req_val   = 1'b0;
    resp_rdy  = 1'b0;
    next_idx  = 0;
    cycle     = 0;
    age       = 0;
    in_flight = 1'b0;
    build_requests();

    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    while (next_idx < num_reqs || in_flight) begin
      @(negedge clk);
      cycle++;
      if (cycle > max_cycles) begin
        fail_run($sformatf("timeout: run did not finish within %0d cycles", max_cycles));
      end
      if (in_flight) begin
        age++;
      end
      // ready only when idle, response exactly resp_latency cycles after accept
      check_ctrl("req_rdy", req_rdy, !in_flight);
      check_ctrl("resp_val", resp_val, in_flight && age >= resp_latency);
      // held response compared every cycle, so any change while stalled is caught
      if (resp_val) begin
        check_resp(resp_msg, exp_q[0]);
      end
      accept = req_val && req_rdy;
      give   = resp_val && resp_rdy;
      if (accept) begin
        exp_q.push_back(model_resp(req_q[next_idx]));
        in_flight = 1'b1;
        age       = 0;
      end
      if (give) begin
        void'(exp_q.pop_front());
        in_flight = 1'b0;
      end

      @(posedge clk);
      resp_rdy <= 1'($urandom_range(1));
      if (accept) begin
        next_idx++;
      end
      // a presented request stays until taken, new ones come after random gaps
      if (!req_val || accept) begin
        if (next_idx < num_reqs && $urandom_range(2) != 0) begin
          req_msg <= req_q[next_idx];
          req_val <= 1'b1;
        end else begin
          req_val <= 1'b0;
        end
      end
    end

    // idle again after the last transfer
    @(negedge clk);
    check_ctrl("req_rdy", req_rdy, 1'b1);
    check_ctrl("resp_val", resp_val, 1'b0);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: src.f
imuldiv_core_pkg.sv
imuldiv_msg_pkg.sv
imuldiv_mul_dpath.sv
imuldiv_mul_ctrl.sv
imuldiv_int_mul_iterative.sv
imuldiv_int_div_iterative.sv
imuldiv_dispatch.sv
imuldiv_unit.sv
tb_imuldiv_unit.sv

// File: Makefile
TOP := tb_imuldiv_unit

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
